// File: common/id_pkg.sv
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_ALU_OP = 12;

    // bit positions inside the one-hot alu_op
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd1;    // link register for bl

    typedef struct packed {
        logic [16:0] op;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] i12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] i20;
        logic [4:0]  rd;
    } fmt_1ri20_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] i16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    // b and bl split the offset, high part sits in the low bits
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
        fmt_2ri16_t fmt_2ri16;
        fmt_i26_t   fmt_i26;
    } inst_word_u;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_t;

    typedef struct packed {
        inst_word_u      inst;
        logic [XLEN-1:0] pc;
    } if_to_id_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_bus_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } fwd_t;

    typedef struct packed {
        logic res_from_mem;    // EX result is only an address for loads
        fwd_t fwd;
    } ex_fwd_t;

    typedef struct packed {
        logic [NUM_ALU_OP-1:0] alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_rd;
        logic                  need_r1;
        logic                  need_r2;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        logic                  res_from_mem;
        logic                  mem_we;
        mem_size_t             mem_size;
        logic                  mem_unsigned;
        logic                  is_jirl;
        logic                  is_b_or_bl;
        br_cond_t              br_cond;
        logic [XLEN-1:0]       br_offs;    // already shifted and sign-extended
        logic [XLEN-1:0]       imm;
    } dec_ctrl_t;

    typedef struct packed {
        logic [NUM_ALU_OP-1:0] alu_op;
        logic                  res_from_mem;
        logic [XLEN-1:0]       alu_src1;
        logic [XLEN-1:0]       alu_src2;
        logic                  mem_we;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        logic [XLEN-1:0]       rkd_value;
        logic [XLEN-1:0]       pc;
        mem_size_t             mem_size;
        logic                  mem_unsigned;
    } id_to_ex_t;

endpackage

// File: decode/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import id_pkg::*;
(
    input  inst_word_u inst,
    output dec_ctrl_t  ctrl
);
    // opcode fields, one per format view
    wire [16:0] op_3r    = inst.fmt_3r.op;
    wire [9:0]  op_2ri12 = inst.fmt_2ri12.op;
    wire [6:0]  op_1ri20 = inst.fmt_1ri20.op;
    wire [5:0]  op_2ri16 = inst.fmt_2ri16.op;
    wire [5:0]  op_i26   = inst.fmt_i26.op;

    wire [11:0] i12 = inst.fmt_2ri12.i12;
    wire [19:0] i20 = inst.fmt_1ri20.i20;
    wire [15:0] i16 = inst.fmt_2ri16.i16;
    wire [25:0] i26 = {inst.fmt_i26.offs_hi, inst.fmt_i26.offs_lo};

    wire inst_add_w  = op_3r == 17'h00020;
    wire inst_sub_w  = op_3r == 17'h00022;
    wire inst_slt    = op_3r == 17'h00024;
    wire inst_sltu   = op_3r == 17'h00025;
    wire inst_nor    = op_3r == 17'h00028;
    wire inst_and    = op_3r == 17'h00029;
    wire inst_or     = op_3r == 17'h0002a;
    wire inst_xor    = op_3r == 17'h0002b;
    wire inst_sll_w  = op_3r == 17'h0002e;
    wire inst_srl_w  = op_3r == 17'h0002f;
    wire inst_sra_w  = op_3r == 17'h00030;
    wire inst_slli_w = op_3r == 17'h00081;    // ui5 sits where rk would be
    wire inst_srli_w = op_3r == 17'h00089;
    wire inst_srai_w = op_3r == 17'h00091;

    wire inst_slti   = op_2ri12 == 10'h008;
    wire inst_sltui  = op_2ri12 == 10'h009;
    wire inst_addi_w = op_2ri12 == 10'h00a;
    wire inst_andi   = op_2ri12 == 10'h00d;
    wire inst_ori    = op_2ri12 == 10'h00e;
    wire inst_xori   = op_2ri12 == 10'h00f;
    wire inst_ld_b   = op_2ri12 == 10'h0a0;
    wire inst_ld_h   = op_2ri12 == 10'h0a1;
    wire inst_ld_w   = op_2ri12 == 10'h0a2;
    wire inst_st_b   = op_2ri12 == 10'h0a4;
    wire inst_st_h   = op_2ri12 == 10'h0a5;
    wire inst_st_w   = op_2ri12 == 10'h0a6;
    wire inst_ld_bu  = op_2ri12 == 10'h0a8;
    wire inst_ld_hu  = op_2ri12 == 10'h0a9;

    wire inst_lu12i_w   = op_1ri20 == 7'h0a;
    wire inst_pcaddu12i = op_1ri20 == 7'h0e;

    wire inst_jirl = op_2ri16 == 6'h13;
    wire inst_beq  = op_2ri16 == 6'h16;
    wire inst_bne  = op_2ri16 == 6'h17;
    wire inst_blt  = op_2ri16 == 6'h18;
    wire inst_bge  = op_2ri16 == 6'h19;
    wire inst_bltu = op_2ri16 == 6'h1a;
    wire inst_bgeu = op_2ri16 == 6'h1b;
    wire inst_b    = op_i26 == 6'h14;
    wire inst_bl   = op_i26 == 6'h15;

    wire is_3r = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire is_shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
    wire is_alu_imm   = inst_addi_w | inst_slti | inst_sltui | inst_andi | inst_ori | inst_xori;
    wire is_ui12      = inst_andi | inst_ori | inst_xori;
    wire is_u20       = inst_lu12i_w | inst_pcaddu12i;
    wire is_load      = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    wire is_store     = inst_st_b | inst_st_h | inst_st_w;
    wire is_cond_br   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    wire is_link      = inst_jirl | inst_bl;    // writes pc + 4

    always_comb begin
        ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | is_load | is_store | is_link
                                | inst_pcaddu12i;
        ctrl.alu_op[ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[ALU_LUI]  = inst_lu12i_w;

        ctrl.src1_is_pc  = is_link | inst_pcaddu12i;
        ctrl.src2_is_imm = is_shift_imm | is_alu_imm | is_u20 | is_load | is_store | is_link;
        ctrl.src2_is_rd  = is_store | is_cond_br;    // store data or compare operand
        ctrl.need_r1     = is_3r | is_shift_imm | is_alu_imm | is_load | is_store
                           | inst_jirl | is_cond_br;
        ctrl.need_r2     = is_3r | is_store | is_cond_br;
        ctrl.rj          = inst.fmt_3r.rj;
        ctrl.rk          = inst.fmt_3r.rk;
        ctrl.rd          = inst.fmt_3r.rd;

        // unknown words fall through with no write and no memory access
        ctrl.rf_we        = is_3r | is_shift_imm | is_alu_imm | is_u20 | is_load | is_link;
        ctrl.rf_waddr     = inst_bl ? RA_REG : inst.fmt_3r.rd;
        ctrl.res_from_mem = is_load;
        ctrl.mem_we       = is_store;
        if (is_load || is_store)
            ctrl.mem_size = mem_size_t'(op_2ri12[1:0]);    // 00 b, 01 h, 10 w
        else
            ctrl.mem_size = MEM_WORD;
        ctrl.mem_unsigned = is_load & op_2ri12[3];

        ctrl.is_jirl    = inst_jirl;
        ctrl.is_b_or_bl = inst_b | inst_bl;
        ctrl.br_offs    = (inst_b | inst_bl) ? {{(XLEN-28){i26[25]}}, i26, 2'b00}
                                             : {{(XLEN-18){i16[15]}}, i16, 2'b00};

        if (is_link)
            ctrl.imm = XLEN'(4);
        else if (is_u20)
            ctrl.imm = {i20, 12'b0};
        else if (is_ui12)
            ctrl.imm = {{(XLEN-12){1'b0}}, i12};
        else
            ctrl.imm = {{(XLEN-12){i12[11]}}, i12};    // shifts only use the low 5 bits
    end

    always_comb begin
        case ({is_cond_br, op_2ri16})
            7'h56:   ctrl.br_cond = BR_EQ;
            7'h57:   ctrl.br_cond = BR_NE;
            7'h58:   ctrl.br_cond = BR_LT;
            7'h59:   ctrl.br_cond = BR_GE;
            7'h5a:   ctrl.br_cond = BR_LTU;
            7'h5b:   ctrl.br_cond = BR_GEU;
            default: ctrl.br_cond = BR_NONE;
        endcase
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    output logic [XLEN-1:0]       rdata1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);
    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass here, WB forwarding covers the write cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: design/operand_forward.sv
`timescale 1ns/1ps

module operand_forward
    import id_pkg::*;
(
    input  dec_ctrl_t             ctrl,
    output logic [REG_ADDR_W-1:0] rf_raddr1,
    output logic [REG_ADDR_W-1:0] rf_raddr2,
    input  logic [XLEN-1:0]       rf_rdata1,
    input  logic [XLEN-1:0]       rf_rdata2,
    input  ex_fwd_t               ex_fwd,
    input  fwd_t                  mem_fwd,
    input  fwd_t                  wb_fwd,
    output logic [XLEN-1:0]       rj_value,
    output logic [XLEN-1:0]       rkd_value,
    output logic                  stall
);
    logic r1_ex;
    logic r1_mem;
    logic r1_wb;
    logic r2_ex;
    logic r2_mem;
    logic r2_wb;

    // needed nonzero source that a later stage is about to write
    function automatic logic hit(input fwd_t f, input logic [REG_ADDR_W-1:0] addr,
                                 input logic need);
        return need && (addr != '0) && f.we && (f.waddr == addr);
    endfunction

    assign rf_raddr1 = ctrl.rj;
    assign rf_raddr2 = ctrl.src2_is_rd ? ctrl.rd : ctrl.rk;

    assign r1_ex  = hit(ex_fwd.fwd, rf_raddr1, ctrl.need_r1);
    assign r1_mem = hit(mem_fwd, rf_raddr1, ctrl.need_r1);
    assign r1_wb  = hit(wb_fwd, rf_raddr1, ctrl.need_r1);
    assign r2_ex  = hit(ex_fwd.fwd, rf_raddr2, ctrl.need_r2);
    assign r2_mem = hit(mem_fwd, rf_raddr2, ctrl.need_r2);
    assign r2_wb  = hit(wb_fwd, rf_raddr2, ctrl.need_r2);

    // youngest producer wins
    assign rj_value  = r1_ex  ? ex_fwd.fwd.wdata :
                       r1_mem ? mem_fwd.wdata :
                       r1_wb  ? wb_fwd.wdata : rf_rdata1;
    assign rkd_value = r2_ex  ? ex_fwd.fwd.wdata :
                       r2_mem ? mem_fwd.wdata :
                       r2_wb  ? wb_fwd.wdata : rf_rdata2;

    assign stall = ex_fwd.res_from_mem & (r1_ex | r2_ex);    // load data not back yet

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import id_pkg::*;
(
    input  dec_ctrl_t       ctrl,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    input  logic            id_valid,
    output br_bus_t         br_bus
);
    logic rj_eq_rd;
    logic rj_lt_rd;
    logic rj_ltu_rd;
    logic cond_true;
    logic [XLEN-1:0] base;

    assign rj_eq_rd  = rj_value == rkd_value;
    assign rj_lt_rd  = $signed(rj_value) < $signed(rkd_value);
    assign rj_ltu_rd = rj_value < rkd_value;

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   cond_true = rj_eq_rd;
            BR_NE:   cond_true = !rj_eq_rd;
            BR_LT:   cond_true = rj_lt_rd;
            BR_GE:   cond_true = !rj_lt_rd;
            BR_LTU:  cond_true = rj_ltu_rd;
            BR_GEU:  cond_true = !rj_ltu_rd;
            default: cond_true = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign base = ctrl.is_jirl ? rj_value : pc;

    always_comb begin
        br_bus.taken  = id_valid & (cond_true | ctrl.is_b_or_bl | ctrl.is_jirl);
        br_bus.target = base + ctrl.br_offs;
    end

endmodule

// File: design/id_stage.sv
`timescale 1ns/1ps

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      if_to_id_valid,
    input  if_to_id_t if_bus,
    output logic      id_allowin,
    output br_bus_t   br_bus,
    input  logic      ex_allowin,
    output logic      id_to_ex_valid,
    output id_to_ex_t ex_bus,
    input  ex_fwd_t   ex_fwd,
    input  fwd_t      mem_fwd,
    input  fwd_t      wb_fwd
);
    logic                  id_valid;
    if_to_id_t             id_hold;    // latched word and pc
    dec_ctrl_t             ctrl;
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [XLEN-1:0]       rj_value;
    logic [XLEN-1:0]       rkd_value;
    logic                  stall;

    assign id_allowin     = !id_valid || (!stall && ex_allowin);
    assign id_to_ex_valid = id_valid && !stall;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_bus.taken) begin
            id_valid <= 1'b0;    // flush beats a new word
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_hold <= '0;
        end else if (if_to_id_valid && id_allowin && !br_bus.taken) begin
            id_hold <= if_bus;
        end
    end

    inst_decoder u_decoder (
        .inst (id_hold.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (wb_fwd.we),
        .waddr  (wb_fwd.waddr),
        .wdata  (wb_fwd.wdata)
    );

    operand_forward u_forward (
        .ctrl      (ctrl),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_branch (
        .ctrl      (ctrl),
        .pc        (id_hold.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .id_valid  (id_valid),
        .br_bus    (br_bus)
    );

    always_comb begin
        ex_bus.alu_op       = ctrl.alu_op;
        ex_bus.res_from_mem = ctrl.res_from_mem & id_valid;
        ex_bus.alu_src1     = ctrl.src1_is_pc ? id_hold.pc : rj_value;
        ex_bus.alu_src2     = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        ex_bus.mem_we       = ctrl.mem_we & id_valid;    // no side effects from a bubble
        ex_bus.rf_we        = ctrl.rf_we & id_valid;
        ex_bus.rf_waddr     = ctrl.rf_waddr;
        ex_bus.rkd_value    = rkd_value;     // store data
        ex_bus.pc           = id_hold.pc;
        ex_bus.mem_size     = ctrl.mem_size;
        ex_bus.mem_unsigned = ctrl.mem_unsigned;
    end

    // EX sees a steady offer until it takes it
    a_ex_bus_hold: assert property (@(posedge clk) disable iff (!resetn)
        id_to_ex_valid && !ex_allowin && !br_bus.taken |=> $stable(ex_bus))
        else $error("ex_bus changed while held off by EX");

endmodule

// File: bench/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage
    import id_pkg::*;
;
    logic      clk = 1'b0;
    logic      resetn;
    logic      if_to_id_valid;
    if_to_id_t if_bus;
    logic      id_allowin;
    br_bus_t   br_bus;
    logic      ex_allowin;
    logic      id_to_ex_valid;
    id_to_ex_t ex_bus;
    ex_fwd_t   ex_fwd;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;

    logic [31:0] model [32];    // mirror of the register file
    int          cycles = 0;

    id_stage DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 3000) begin
            $display("Something failed");
            $fatal(1, "timeout, the tests did not finish within 3000 cycles");
        end
    end

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] i12,
                                              input logic [4:0] rj, rd);
        return {op, i12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(input logic [5:0] op, input logic [15:0] i16,
                                              input logic [4:0] rj, rd);
        return {op, i16, rj, rd};
    endfunction

    function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
        return 32'($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_reg(input logic [4:0] r, input logic [31:0] v);
        @(negedge clk);
        wb_fwd.we    = 1'b1;
        wb_fwd.waddr = r;
        wb_fwd.wdata = v;
        if (r != 0) model[r] = v;
        @(negedge clk);
        wb_fwd = '0;
    endtask

    // offer one word, return at the negedge after it is latched
    task automatic issue(input logic [31:0] word, input logic [31:0] pc);
        @(negedge clk);
        while (!id_allowin) @(negedge clk);
        if_to_id_valid = 1'b1;
        if_bus         = {word, pc};
        @(negedge clk);
        if_to_id_valid = 1'b0;
    endtask

    task automatic alu_rr_test();
        logic [16:0] ops [11];
        int          pos [11];
        logic [4:0]  rj, rk, rd;
        ops = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29, 17'h2a, 17'h2b,
                17'h2e, 17'h2f, 17'h30};
        pos = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
                ALU_SLL, ALU_SRL, ALU_SRA};
        for (int i = 0; i < 12; i++) begin
            rj = (i == 11) ? 5'd0 : 5'($urandom_range(2, 31));    // last pass reads r0
            rk = 5'($urandom_range(2, 31));
            rd = 5'($urandom_range(2, 31));
            issue(enc_3r(ops[i % 11], rk, rj, rd), 32'h1c00_0000 + 4 * i);
            expect_eq(32'(ex_bus.alu_op), 32'(1) << pos[i % 11], "3R alu_op");
            expect_eq(ex_bus.alu_src1, (rj == 0) ? 32'h0 : model[rj], "3R alu_src1");
            expect_eq(ex_bus.alu_src2, model[rk], "3R alu_src2");
            expect_eq(32'({ex_bus.rf_we, ex_bus.rf_waddr}), 32'({1'b1, rd}), "3R destination");
        end
    endtask

    task automatic imm_mem_test();
        logic [9:0]  ops [5];
        logic [11:0] i12;
        logic [19:0] i20;
        logic [31:0] pc;
        ops = '{10'h00a, 10'h008, 10'h00d, 10'h00e, 10'h00f};    // addi slti andi ori xori
        for (int i = 0; i < 5; i++) begin
            i12 = 12'($urandom);
            issue(enc_2ri12(ops[i], i12, 5'd4, 5'd5), 32'h100);
            expect_eq(ex_bus.alu_src2, (i < 2) ? sext({20'h0, i12}, 12) : {20'h0, i12},
                      "i12 immediate");
            expect_eq(ex_bus.alu_src1, model[4], "i12 source");
        end
        i20 = 20'($urandom);
        issue({7'h0a, i20, 5'd6}, 32'h200);
        expect_eq(ex_bus.alu_src2, {i20, 12'h0}, "lu12i.w immediate");
        expect_eq(32'(ex_bus.alu_op), 32'(1) << ALU_LUI, "lu12i.w alu_op");
        pc = $urandom & ~32'h3;
        issue({7'h0e, i20, 5'd6}, pc);
        expect_eq(ex_bus.alu_src1, pc, "pcaddu12i src1");
        expect_eq(ex_bus.alu_src2, {i20, 12'h0}, "pcaddu12i immediate");
        ops = '{10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9};    // ld.b h w bu hu
        for (int i = 0; i < 5; i++) begin
            i12 = 12'($urandom);
            issue(enc_2ri12(ops[i], i12, 5'd7, 5'd8), 32'h300);
            expect_eq(32'({ex_bus.res_from_mem, ex_bus.rf_we, ex_bus.mem_we}), 32'b110,
                      "load flags");
            expect_eq(32'(ex_bus.mem_size), (i > 2) ? i - 3 : i, "load size");
            expect_eq(32'(ex_bus.mem_unsigned), 32'(i > 2), "load sign");
            expect_eq(ex_bus.alu_src2, sext({20'h0, i12}, 12), "load offset");
        end
        for (int i = 0; i < 3; i++) begin    // st.b h w
            issue(enc_2ri12(10'h0a4 + 10'(i), 12'h010, 5'd9, 5'd10), 32'h400);
            expect_eq(32'({ex_bus.mem_we, ex_bus.rf_we, ex_bus.mem_size}), 32'({2'b10, 2'(i)}),
                      "store flags");
            expect_eq(ex_bus.rkd_value, model[10], "store data");
        end
    endtask

    task automatic fwd_case(input logic [4:0] ex_a, input logic ex_we, input logic [4:0] mem_a,
                            input logic mem_we, input logic wb_we, input int sel);
        logic [31:0] e, m, w, exp;
        e = $urandom;
        m = $urandom;
        w = $urandom;
        @(negedge clk);
        ex_fwd.fwd = '{we: ex_we, waddr: ex_a, wdata: e};
        mem_fwd    = '{we: mem_we, waddr: mem_a, wdata: m};
        wb_fwd     = '{we: wb_we, waddr: 5'd5, wdata: w};
        issue(enc_3r(17'h20, 5'd11, 5'd5, 5'd6), 32'h500);    // add.w reading r5
        exp = (sel == 0) ? e : (sel == 1) ? m : (sel == 2) ? w : model[5];
        expect_eq(ex_bus.alu_src1, exp, "forwarded rj");
        if (wb_we) model[5] = w;
    endtask

    task automatic forward_test();
        fwd_case(5'd5, 1'b1, 5'd5, 1'b1, 1'b1, 0);
        fwd_case(5'd5, 1'b0, 5'd5, 1'b1, 1'b1, 1);
        fwd_case(5'd0, 1'b1, 5'd0, 1'b1, 1'b1, 2);
        fwd_case(5'd0, 1'b1, 5'd5, 1'b0, 1'b0, 3);
        @(negedge clk);
        ex_fwd  = '0;
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    task automatic stall_test();
        set_reg(7, $urandom);
        ex_fwd = '{res_from_mem: 1'b1, fwd: '{we: 1'b1, waddr: 5'd7, wdata: $urandom}};
        issue(enc_3r(17'h22, 5'd7, 5'd7, 5'd3), 32'h600);
        repeat (3) begin
            expect_eq(32'({id_to_ex_valid, id_allowin}), 32'b0, "valid and allowin in stall");
            @(negedge clk);
        end
        ex_fwd = '0;
        #5;
        expect_eq(32'(id_to_ex_valid), 32'd1, "valid after stall");
        expect_eq(32'(ex_bus.alu_op), 32'(1) << ALU_SUB, "alu_op after stall");
        expect_eq(ex_bus.pc, 32'h600, "pc after stall");
        expect_eq(32'(ex_bus.rf_waddr), 32'd3, "rd after stall");
        expect_eq(ex_bus.alu_src1, model[7], "rj after stall");
        expect_eq(ex_bus.alu_src2, model[7], "rk after stall");
    endtask

    task automatic branch_test();
        logic [31:0] a, b, pc;
        logic [15:0] off;
        logic [25:0] off26;
        logic        exp_taken;
        for (int i = 0; i < 24; i++) begin
            a = $urandom;
            b = (i / 6 == 3) ? a : $urandom;    // last round compares equal values
            set_reg(8, a);
            set_reg(9, b);
            off = 16'($urandom);
            pc  = $urandom & ~32'h3;
            case (i % 6)
                0: exp_taken = a == b;
                1: exp_taken = a != b;
                2: exp_taken = $signed(a) < $signed(b);
                3: exp_taken = $signed(a) >= $signed(b);
                4: exp_taken = a < b;
                default: exp_taken = a >= b;
            endcase
            issue(enc_2ri16(6'h16 + 6'(i % 6), off, 5'd8, 5'd9), pc);
            expect_eq(32'(br_bus.taken), 32'(exp_taken), "conditional branch taken");
            expect_eq(br_bus.target, pc + sext({14'h0, off, 2'b00}, 18), "conditional target");
        end
        off26 = 26'($urandom);
        issue({6'h15, off26[15:0], off26[25:16]}, 32'h800);
        expect_eq(32'({br_bus.taken, ex_bus.rf_waddr}), 32'({1'b1, RA_REG}), "bl link");
        expect_eq(ex_bus.alu_src2, 32'd4, "bl src2");
        expect_eq(br_bus.target, 32'h800 + sext({4'h0, off26, 2'b00}, 28), "bl target");
        issue(enc_2ri16(6'h13, off, 5'd8, 5'd12), 32'h900);
        expect_eq(br_bus.target, model[8] + sext({14'h0, off, 2'b00}, 18), "jirl target");
        // fetch keeps offering while the taken branch flushes
        issue({6'h14, 16'h0010, 10'h0}, 32'ha00);
        if_to_id_valid = 1'b1;
        if_bus         = {enc_3r(17'h20, 5'd2, 5'd3, 5'd4), 32'ha04};
        @(negedge clk);
        if_to_id_valid = 1'b0;
        expect_eq(32'(id_to_ex_valid), 32'd0, "valid after taken branch");
    endtask

    task automatic backpressure_test();
        issue(enc_3r(17'h2b, 5'd13, 5'd14, 5'd15), 32'hb00);
        ex_allowin     = 1'b0;
        if_to_id_valid = 1'b1;
        if_bus         = {enc_3r(17'h29, 5'd16, 5'd17, 5'd18), 32'hb04};
        repeat (4) begin
            @(negedge clk);
            expect_eq(32'(id_allowin), 32'd0, "allowin under back-pressure");
            expect_eq(ex_bus.alu_src1, model[14], "held alu_src1");
            expect_eq(ex_bus.pc, 32'hb00, "held pc");
        end
        ex_allowin = 1'b1;
        @(negedge clk);
        if_to_id_valid = 1'b0;
        expect_eq(32'(id_to_ex_valid), 32'd1, "valid after release");
        expect_eq(ex_bus.pc, 32'hb04, "next word after release");
    endtask

    initial begin
        void'($urandom(32'h3cdb));
        resetn         = 1'b0;
        if_to_id_valid = 1'b0;
        if_bus         = '0;
        ex_allowin     = 1'b1;
        ex_fwd         = '0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        model[0]       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        expect_eq(32'({id_allowin, id_to_ex_valid, br_bus.taken}), 32'b100,
                  "state after reset");
        for (int r = 1; r < 32; r++) set_reg(5'(r), $urandom);
        alu_rr_test();
        imm_mem_test();
        forward_test();
        stall_test();
        branch_test();
        backpressure_test();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: project.f
common/id_pkg.sv
decode/inst_decoder.sv
design/regfile.sv
design/operand_forward.sv
design/branch_unit.sv
design/id_stage.sv
bench/tb_id_stage.sv

// File: Makefile
TOP = tb_id_stage

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
